/* dv/pipeChecker.sv */
`default_nettype none

module pipeChecker import archPkg::*, ctrlPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  regIdx_t srcAD, srcBD, destD,
  input  logic    useAD, useBD, regWriteD, memToRegD,
  input  logic    dStall, iStall, branchTakenE,
  input  logic    prefetchAbortE, dataAbort, irq, fiq, undefinedInstrE, swiE,
  input  fwdSel_t forwardAE, forwardBE,
  input  logic    stallF, stallD, stallE, stallM, stallW,
  input  logic    flushD, flushE, flushM, flushW,
  input  pcSel_t  pcInSelect,
  output int      errCount
);

  // Shadow E/M/W slots kept from the stage register rule
  logic    rwE, rwM, rwW, mrE;
  regIdx_t dE, dM, dW;
  // Shadow E-stage sources of both operands
  regIdx_t sAE, sBE;
  logic    vAE, vBE;
  int      errors = 0;

  assign errCount = errors;

  // Forward select for one E-stage source, memory slot first
  function automatic fwdSel_t fwdOf(input logic valid, input regIdx_t src);
    if (valid && rwM && dM == src) return FWD_MEM;
    if (valid && rwW && dW == src) return FWD_WB;
    return FWD_NONE;
  endfunction

  // Expected outputs packed as fwdA, fwdB, stallF..W, flushD..W, pcSel
  function automatic logic [14:0] expectedOutputs();
    logic   ldr;
    logic   mem;
    logic   exc;
    pcSel_t pc;
    ldr = (useAD && rwE && mrE && dE == srcAD) || (useBD && rwE && mrE && dE == srcBD);
    mem = dStall || iStall;
    exc = prefetchAbortE || dataAbort || irq || fiq || undefinedInstrE || swiE;
    // Return offset by exception priority
    if (prefetchAbortE) pc = PCSEL_PLUS8;
    else if (dataAbort) pc = PCSEL_PLUS0;
    else if (irq || fiq) pc = PCSEL_PLUS8;
    else if (undefinedInstrE) pc = PCSEL_PLUS4;
    else if (swiE) pc = PCSEL_PLUS0;
    else pc = PCSEL_PLUS8;
    return {fwdOf(vAE, sAE), fwdOf(vBE, sBE), ldr | mem, ldr | mem, mem, mem, mem,
            branchTakenE | iStall | exc, (ldr | branchTakenE | exc) & ~mem, exc, mem, pc};
  endfunction

  // Advance the shadow pipe with the expected controls of this cycle
  always @(posedge clk) begin : shadowUpdate
    logic [14:0] e;
    e = expectedOutputs();
    if (reset || e[4]) begin
      rwE <= 1'b0;
      mrE <= 1'b0;
      vAE <= 1'b0;
      vBE <= 1'b0;
    end else if (!e[8]) begin
      rwE <= regWriteD;
      mrE <= memToRegD;
      dE  <= destD;
      sAE <= srcAD;
      sBE <= srcBD;
      vAE <= useAD;
      vBE <= useBD;
    end
    if (reset || e[3]) begin
      rwM <= 1'b0;
    end else if (!e[7]) begin
      rwM <= rwE;
      dM  <= dE;
    end
    if (reset || e[2]) begin
      rwW <= 1'b0;
    end else if (!e[6]) begin
      rwW <= rwM;
      dW  <= dM;
    end
  end

  task automatic checkField(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s got 0x%0h expected 0x%0h at time %0t", name, got, exp, $time);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin : compare
    logic [14:0] e;
    e = expectedOutputs();
    if (!reset) begin
      checkField("forwardAE", forwardAE, e[14:13]);
      checkField("forwardBE", forwardBE, e[12:11]);
      checkField("stallF", {1'b0, stallF}, {1'b0, e[10]});
      checkField("stallD", {1'b0, stallD}, {1'b0, e[9]});
      checkField("stallE", {1'b0, stallE}, {1'b0, e[8]});
      checkField("stallM", {1'b0, stallM}, {1'b0, e[7]});
      checkField("stallW", {1'b0, stallW}, {1'b0, e[6]});
      checkField("flushD", {1'b0, flushD}, {1'b0, e[5]});
      checkField("flushE", {1'b0, flushE}, {1'b0, e[4]});
      checkField("flushM", {1'b0, flushM}, {1'b0, e[3]});
      checkField("flushW", {1'b0, flushW}, {1'b0, e[2]});
      checkField("pcInSelect", pcInSelect, e[1:0]);
    end
  end

endmodule

`default_nettype wire

/* dv/tbPipeControl.sv */
`default_nettype none

module tbPipeControl import archPkg::*, ctrlPkg::*; ();

  // Directed part is about 110 cycles, random part 2000, rest is margin
  localparam int RANDOM_CYCLES  = 2000;
  localparam int TIMEOUT_CYCLES = 3000;

  // Side inputs as {dStall, iStall, branchTakenE, six exception lines}
  localparam logic [8:0] QUIET  = 9'h000;
  localparam logic [8:0] DSTALL = 9'h100;
  localparam logic [8:0] ISTALL = 9'h080;
  localparam logic [8:0] BRANCH = 9'h040;

  logic    clk = 1'b0;
  logic    reset;
  regIdx_t srcAD, srcBD, destD;
  logic    useAD, useBD, regWriteD, memToRegD;
  logic    dStall, iStall, branchTakenE;
  logic    prefetchAbortE, dataAbort, irq, fiq, undefinedInstrE, swiE;
  fwdSel_t forwardAE, forwardBE;
  logic    stallF, stallD, stallE, stallM, stallW;
  logic    flushD, flushE, flushM, flushW;
  pcSel_t  pcInSelect;
  int      errCount;
  int      cycleCount = 0;
  logic [31:0] lfsr = 32'h154c8a54;
  logic [31:0] bits;
  logic [8:0]  side;

  pipeControl u_pipeControl (.*);
  pipeChecker u_pipeChecker (.*);

  always #10 clk = ~clk;

  // Galois right shift, taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // One decode instruction plus side inputs for the next clock cycle
  task automatic issue(input regIdx_t a, input logic ua, input regIdx_t b, input logic ub,
                       input regIdx_t d, input logic rw, input logic mr, input logic [8:0] s);
    @(posedge clk);
    srcAD     <= a;
    useAD     <= ua;
    srcBD     <= b;
    useBD     <= ub;
    destD     <= d;
    regWriteD <= rw;
    memToRegD <= mr;
    {dStall, iStall, branchTakenE, prefetchAbortE, dataAbort, irq, fiq,
     undefinedInstrE, swiE} <= s;
  endtask

  // Hang guard
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: stimulus still running after %0d cycles", cycleCount);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    {srcAD, srcBD, destD, useAD, useBD, regWriteD, memToRegD} = '0;
    {dStall, iStall, branchTakenE, prefetchAbortE, dataAbort, irq, fiq,
     undefinedInstrE, swiE} = QUIET;
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // Quiet pipe after reset
    repeat (3) issue(0, 0, 0, 0, 0, 0, 0, QUIET);
    // Two writers of r1, the reader sees the younger one in M
    issue(0, 0, 0, 0, 1, 1, 0, QUIET);
    issue(0, 0, 0, 0, 1, 1, 0, QUIET);
    issue(1, 1, 2, 0, 0, 0, 0, QUIET);
    // Writer of r2 two instructions back forwards from W
    issue(0, 0, 0, 0, 2, 1, 0, QUIET);
    issue(0, 0, 0, 0, 6, 1, 0, QUIET);
    issue(5, 0, 2, 1, 0, 0, 0, QUIET);
    issue(0, 0, 0, 0, 0, 0, 0, QUIET);
    // Load of r3 and a dependent op, decode repeats it while held
    issue(0, 0, 0, 0, 3, 1, 1, QUIET);
    issue(3, 1, 0, 0, 4, 1, 0, QUIET);
    issue(3, 1, 0, 0, 4, 1, 0, QUIET);
    repeat (2) issue(0, 0, 0, 0, 0, 0, 0, QUIET);
    // Memory stalls freeze E and M around a forward
    issue(0, 0, 0, 0, 4, 1, 0, QUIET);
    issue(4, 1, 4, 1, 0, 0, 0, DSTALL);
    issue(4, 1, 4, 1, 0, 0, 0, DSTALL);
    issue(4, 1, 4, 1, 0, 0, 0, ISTALL);
    issue(4, 1, 4, 1, 0, 0, 0, QUIET);
    repeat (2) issue(0, 0, 0, 0, 0, 0, 0, QUIET);
    // Writer of r5 is killed by the branch
    issue(0, 0, 0, 0, 5, 1, 0, BRANCH);
    issue(5, 1, 5, 1, 0, 0, 0, QUIET);
    repeat (2) issue(0, 0, 0, 0, 0, 0, 0, QUIET);
    // Every exception combination
    for (int e = 0; e < 64; e++) begin
      issue(regIdx_t'(e % 8), 1, 0, 0, 7, 1, 0, {3'b000, e[5:0]});
    end
    repeat (3) issue(0, 0, 0, 0, 0, 0, 0, QUIET);
    // Random traffic on r0..r7, side inputs rare
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      takeBits(13, bits);
      for (int k = 0; k < 9; k++) begin : sideBits
        logic [31:0] p;
        takeBits(4, p);
        side[k] = (p[3:0] == 4'd0);
      end
      issue({1'b0, bits[2:0]}, bits[9], {1'b0, bits[5:3]}, bits[10], {1'b0, bits[8:6]},
            bits[11], bits[12] & bits[11], side);
    end
    repeat (3) issue(0, 0, 0, 0, 0, 0, 0, QUIET);
    @(posedge clk);
    $display("Closing: %0d mismatches over %0d cycles", errCount, cycleCount);
    if (errCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/archPkg.sv
rtl/ctrlPkg.sv
rtl/pipeInterfaces.sv
rtl/stageTracker.sv
rtl/operandForward.sv
rtl/hazardControl.sv
rtl/pipeControl.sv
dv/pipeChecker.sv
dv/tbPipeControl.sv

/* rtl/archPkg.sv */
`default_nettype none

package archPkg;

  // Sixteen architectural registers, r15 is the PC
  localparam int REG_IDX_W = 4;

  // Register index as it travels down the pipe
  typedef logic [REG_IDX_W-1:0] regIdx_t;

  // Source operands checked for hazards
  // One operand unit per source
  localparam int NUM_SRC = 2;

  // Operand slot numbering inside the source arrays
  localparam int SRC_A = 0;
  localparam int SRC_B = 1;

endpackage

`default_nettype wire

/* rtl/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

  // Execute-stage operand mux select
  typedef logic [1:0] fwdSel_t;

  // Value straight from the register file
  localparam fwdSel_t FWD_NONE = 2'b00;
  // Result sitting in writeback
  localparam fwdSel_t FWD_WB   = 2'b01;
  // ALU result sitting in the memory stage
  localparam fwdSel_t FWD_MEM  = 2'b10;

  // Exception return address offset into r14
  typedef logic [1:0] pcSel_t;

  // Aborted or interrupted instruction, PC is two ahead
  localparam pcSel_t PCSEL_PLUS8 = 2'b00;
  // Undefined instruction
  localparam pcSel_t PCSEL_PLUS4 = 2'b01;
  // Data abort and SWI
  // The link write goes through the pipe one cycle late
  localparam pcSel_t PCSEL_PLUS0 = 2'b10;

  // Number of exception request lines combined in the hazard unit
  localparam int NUM_EXC = 6;

endpackage

`default_nettype wire

/* rtl/hazardControl.sv */
`default_nettype none

module hazardControl import archPkg::*, ctrlPkg::*; (
  input  logic [NUM_SRC-1:0] loadUseHit,
  input  logic               dStall,
  input  logic               iStall,
  input  logic               branchTakenE,
  input  logic               prefetchAbortE,
  input  logic               dataAbort,
  input  logic               irq,
  input  logic               fiq,
  input  logic               undefinedInstrE,
  input  logic               swiE,
  output logic               stallF,
  output logic               stallD,
  output logic               flushD,
  stageCtrl.driver           ctrl,
  output pcSel_t             pcInSelect
);

  logic               ldrStall;
  logic               memStall;
  logic               excTaken;
  logic [NUM_EXC-1:0] excReq;

  // Any operand waiting on a load in E
  assign ldrStall = |loadUseHit;

  // Cache miss on either side freezes the back end
  assign memStall = dStall | iStall;

  assign excReq   = {prefetchAbortE, dataAbort, irq, fiq, undefinedInstrE, swiE};
  assign excTaken = |excReq;

  // Front end holds for load-use and memory waits
  assign stallF = ldrStall | memStall;
  assign stallD = ldrStall | memStall;

  // Back end only holds for memory waits
  assign ctrl.stallE = memStall;
  assign ctrl.stallM = memStall;
  assign ctrl.stallW = memStall;

  // Wrong-path fetch, fetch miss or exception kills decode
  assign flushD = branchTakenE | iStall | excTaken;

  // Bubble into E for load-use, branch or exception
  // A frozen E must not lose its instruction
  assign ctrl.flushE = (ldrStall | branchTakenE | excTaken) & ~memStall;
  assign ctrl.flushM = excTaken;
  // W retires while the pipe is frozen, so it repeats as a bubble
  assign ctrl.flushW = memStall;

  // Return address offset by exception priority
  always_comb begin
    if (prefetchAbortE) begin
      pcInSelect = PCSEL_PLUS8;
    end else if (dataAbort) begin
      pcInSelect = PCSEL_PLUS0;
    end else if (irq) begin
      pcInSelect = PCSEL_PLUS8;
    end else if (fiq) begin
      pcInSelect = PCSEL_PLUS8;
    end else if (undefinedInstrE) begin
      pcInSelect = PCSEL_PLUS4;
    end else if (swiE) begin
      pcInSelect = PCSEL_PLUS0;
    end else begin
      pcInSelect = PCSEL_PLUS8;
    end
  end

endmodule

`default_nettype wire

/* rtl/operandForward.sv */
`default_nettype none

module operandForward import archPkg::*, ctrlPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  regIdx_t srcD,
  input  logic    useD,
  stageCtrl.reader ctrl,
  destBus.reader   dest,
  output fwdSel_t forwardSel,
  output logic    loadUseHit
);

  // Source register of the instruction now in E
  regIdx_t srcE;
  logic    validE;
  logic    hitM;
  logic    hitW;

  // Valid bit follows the E slot rule
  always_ff @(posedge clk) begin
    if (reset || ctrl.flushE) begin
      validE <= 1'b0;
    end else if (!ctrl.stallE) begin
      validE <= useD;
    end
  end

  always_ff @(posedge clk) begin
    if (!ctrl.stallE) begin
      srcE <= srcD;
    end
  end

  // Compare against the two older slots
  assign hitM = validE && dest.regWriteM && (dest.destM == srcE);
  assign hitW = validE && dest.regWriteW && (dest.destW == srcE);

  // Youngest producer wins
  always_comb begin
    if (hitM) begin
      forwardSel = FWD_MEM;
    end else if (hitW) begin
      forwardSel = FWD_WB;
    end else begin
      forwardSel = FWD_NONE;
    end
  end

  // Load in E feeding the instruction in decode
  // Data only exists after the memory stage, so decode has to wait a cycle
  assign loadUseHit = useD && dest.regWriteE && dest.memToRegE &&
                      (dest.destE == srcD);

  // Consumer of a load must never reach E while the load is only in M
  assert property (@(posedge clk) disable iff (reset)
    (loadUseHit && !ctrl.stallE) |=> !validE);

endmodule

`default_nettype wire

/* rtl/pipeControl.sv */
`default_nettype none

module pipeControl import archPkg::*, ctrlPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  regIdx_t srcAD,
  input  regIdx_t srcBD,
  input  logic    useAD,
  input  logic    useBD,
  input  logic    regWriteD,
  input  logic    memToRegD,
  input  regIdx_t destD,
  input  logic    dStall,
  input  logic    iStall,
  input  logic    branchTakenE,
  input  logic    prefetchAbortE,
  input  logic    dataAbort,
  input  logic    irq,
  input  logic    fiq,
  input  logic    undefinedInstrE,
  input  logic    swiE,
  output fwdSel_t forwardAE,
  output fwdSel_t forwardBE,
  output logic    stallF,
  output logic    stallD,
  output logic    stallE,
  output logic    stallM,
  output logic    stallW,
  output logic    flushD,
  output logic    flushE,
  output logic    flushM,
  output logic    flushW,
  output pcSel_t  pcInSelect
);

  destBus   destIf ();
  stageCtrl ctrlIf ();

  // Per-operand wiring for the generate loop
  regIdx_t            srcD [NUM_SRC];
  logic [NUM_SRC-1:0] useD;
  fwdSel_t            fwdSel [NUM_SRC];
  logic [NUM_SRC-1:0] loadUseHit;

  assign srcD[SRC_A] = srcAD;
  assign srcD[SRC_B] = srcBD;
  assign useD        = {useBD, useAD};

  stageTracker u_stageTracker (
    .clk       (clk),
    .reset     (reset),
    .destD     (destD),
    .regWriteD (regWriteD),
    .memToRegD (memToRegD),
    .ctrl      (ctrlIf.reader),
    .dest      (destIf.tracker)
  );

  // One forwarding and load-use unit per source operand
  for (genvar i = 0; i < NUM_SRC; i++) begin : g_operand
    operandForward u_operandForward (
      .clk        (clk),
      .reset      (reset),
      .srcD       (srcD[i]),
      .useD       (useD[i]),
      .ctrl       (ctrlIf.reader),
      .dest       (destIf.reader),
      .forwardSel (fwdSel[i]),
      .loadUseHit (loadUseHit[i])
    );
  end

  hazardControl u_hazardControl (
    .loadUseHit      (loadUseHit),
    .dStall          (dStall),
    .iStall          (iStall),
    .branchTakenE    (branchTakenE),
    .prefetchAbortE  (prefetchAbortE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .undefinedInstrE (undefinedInstrE),
    .swiE            (swiE),
    .stallF          (stallF),
    .stallD          (stallD),
    .flushD          (flushD),
    .ctrl            (ctrlIf.driver),
    .pcInSelect      (pcInSelect)
  );

  assign forwardAE = fwdSel[SRC_A];
  assign forwardBE = fwdSel[SRC_B];

  // Back-end controls leave through plain ports
  assign stallE = ctrlIf.stallE;
  assign stallM = ctrlIf.stallM;
  assign stallW = ctrlIf.stallW;
  assign flushE = ctrlIf.flushE;
  assign flushM = ctrlIf.flushM;
  assign flushW = ctrlIf.flushW;

endmodule

`default_nettype wire

/* rtl/pipeInterfaces.sv */
`default_nettype none

// Destination register of each in-flight instruction
interface destBus import archPkg::*; ();

  // Execute stage slot
  regIdx_t destE;
  logic    regWriteE;
  // Load in E, result not ready before memory returns
  logic    memToRegE;

  // Memory stage slot
  regIdx_t destM;
  logic    regWriteM;

  // Writeback stage slot
  regIdx_t destW;
  logic    regWriteW;

  modport tracker (output destE, regWriteE, memToRegE, destM, regWriteM, destW, regWriteW);
  modport reader  (input  destE, regWriteE, memToRegE, destM, regWriteM, destW, regWriteW);

endinterface

// Per-stage hold and bubble controls for E, M and W
interface stageCtrl ();

  logic stallE;
  logic stallM;
  logic stallW;
  logic flushE;
  logic flushM;
  logic flushW;

  modport driver (output stallE, stallM, stallW, flushE, flushM, flushW);
  modport reader (input  stallE, stallM, stallW, flushE, flushM, flushW);

endinterface

`default_nettype wire

/* rtl/stageTracker.sv */
`default_nettype none

module stageTracker import archPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  regIdx_t destD,
  input  logic    regWriteD,
  input  logic    memToRegD,
  stageCtrl.reader ctrl,
  destBus.tracker  dest
);

  // Slot order in the vectors below is E, M, W
  logic [2:0] stallVec;
  logic [2:0] flushVec;
  logic [2:0] regWriteIn;
  logic [2:0] regWriteQ;
  regIdx_t    destIn [3];
  regIdx_t    destQ  [3];
  // Load flag is only needed while the load sits in E
  logic       memToRegQ;

  assign stallVec = {ctrl.stallW, ctrl.stallM, ctrl.stallE};
  assign flushVec = {ctrl.flushW, ctrl.flushM, ctrl.flushE};

  // Each slot is fed by the stage in front of it
  assign regWriteIn = {regWriteQ[1], regWriteQ[0], regWriteD};
  assign destIn[0]  = destD;
  assign destIn[1]  = destQ[0];
  assign destIn[2]  = destQ[1];

  // Write enables, flush beats stall
  always_ff @(posedge clk) begin
    for (int s = 0; s < 3; s++) begin
      if (reset || flushVec[s]) begin
        regWriteQ[s] <= 1'b0;
      end else if (!stallVec[s]) begin
        regWriteQ[s] <= regWriteIn[s];
      end
    end
  end

  // Register index only matters when the write enable is set
  always_ff @(posedge clk) begin
    for (int s = 0; s < 3; s++) begin
      if (!stallVec[s]) begin
        destQ[s] <= destIn[s];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset || ctrl.flushE) begin
      memToRegQ <= 1'b0;
    end else if (!ctrl.stallE) begin
      memToRegQ <= memToRegD;
    end
  end

  assign dest.destE     = destQ[0];
  assign dest.regWriteE = regWriteQ[0];
  assign dest.memToRegE = memToRegQ;
  assign dest.destM     = destQ[1];
  assign dest.regWriteM = regWriteQ[1];
  assign dest.destW     = destQ[2];
  assign dest.regWriteW = regWriteQ[2];

  // A load in E must also be a register writer, otherwise the load-use stall
  // would wait on a result nobody produces
  assert property (@(posedge clk) disable iff (reset)
    dest.memToRegE |-> dest.regWriteE);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tbPipeControl -f files.f -o simPipeControl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simPipeControl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
